// File: sim.f
+incdir+hdl
hdl/ac97_pkg.sv
hdl/ac97_apb_regs.sv
hdl/ac97_sample_fifo.sv
hdl/ac97_cmd_seq.sv
hdl/ac97_link.sv
hdl/ac97_top.sv
test/ac97_tb.sv

// File: test/ac97_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "ac97_cfg.svh"

module ac97_tb
	import ac97_pkg::*;
;

	localparam int TIMEOUT_CYCLES = 24000;    // About 80 frames plus margin

	logic          ac97_bitclk;
	logic          rst;
	logic          ac97_sdata_in;
	ac97_apb_req_t apb_req;
	ac97_apb_rsp_t apb_rsp;
	logic          ac97_sdata_out;
	logic          ac97_sync;
	logic          ac97_reset_b;

	int           val_errors = 0;
	int           other_errors = 0;
	int           frames_loaded = 0;
	int           frames_checked = 0;
	int           frame0_ones = 0;
	int           cycles;
	logic [23:0]  init_cmds [3];
	logic [31:0]  smp_q [$];         // Expected samples with their accept times
	time          smp_t [$];
	logic [23:0]  cmd_q [$];
	time          cmd_t [$];
	logic [0:255] cap_q [$];
	time          load_q [$];
	logic         codec_req = 1'b0;  // One status frame with a reply
	logic [6:0]   codec_idx;
	logic [15:0]  codec_data;

	ac97_top dut0 (
		.ac97_bitclk   (ac97_bitclk),
		.rst           (rst),
		.apb_req       (apb_req),
		.ac97_sdata_in (ac97_sdata_in),
		.apb_rsp       (apb_rsp),
		.ac97_sdata_out(ac97_sdata_out),
		.ac97_sync     (ac97_sync),
		.ac97_reset_b  (ac97_reset_b)
	);

	initial begin
		ac97_bitclk = 1'b0;
		forever #4 ac97_bitclk = ~ac97_bitclk;
	end

	task automatic check(input logic [255:0] got, input logic [255:0] exp, input string what);
		if (got !== exp) begin
			$display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			val_errors++;
		end
	endtask

	// Expected output frame in transmission order
	function automatic logic [0:255] expected_frame(input logic cmd_v, input logic [23:0] c,
		input logic smp_v, input logic [31:0] s);
		logic [0:255] f;
		f = '0;
		f[0] = 1'b1;
		if (cmd_v) begin
			f[1]     = 1'b1;
			f[16:35] = {c[23], c[22:16], 12'h000};
			if (!c[23]) begin    // Writes only
				f[2]     = 1'b1;
				f[36:55] = {c[15:0], 4'h0};
			end
		end
		if (smp_v) begin
			f[3]     = 1'b1;
			f[4]     = 1'b1;
			f[56:75] = {s[15:0], 4'h0};     // Left
			f[76:95] = {s[31:16], 4'h0};
		end
		return f;
	endfunction

	// Returns on the frame load edge that follows a sync rise
	task automatic wait_load_edge();
		logic prev;
		logic found;
		prev  = 1'b1;
		found = 1'b0;
		while (!found) begin
			@(negedge ac97_bitclk);
			found = ac97_sync && !prev;
			prev  = ac97_sync;
		end
		@(posedge ac97_bitclk);
	endtask

	task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err, output int waits);
		@(posedge ac97_bitclk);
		apb_req <= '{sel: 1'b1, enable: 1'b0, write: wr, addr: addr, wdata: wdata};
		@(posedge ac97_bitclk);
		apb_req.enable <= 1'b1;
		waits = 0;
		@(negedge ac97_bitclk);
		while (!apb_rsp.ready) begin
			waits++;
			@(negedge ac97_bitclk);
		end
		rdata = apb_rsp.rdata;
		err   = apb_rsp.slverr;
		@(posedge ac97_bitclk);    // Completing edge
		apb_req <= '0;
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] rdata);
		logic err;
		int   waits;
		apb_xfer(1'b0, addr, 32'h0, rdata, err, waits);
		check(err, 1'b0, "slverr on register read");
	endtask

	task automatic write_sample(input logic [31:0] s, output int waits);
		logic [31:0] rd;
		logic        err;
		apb_xfer(1'b1, `AC97_REG_SAMPLE, s, rd, err, waits);
		check(err, 1'b0, "slverr on SAMPLE write");
		smp_q.push_back(s);
		smp_t.push_back($time);
	endtask

	task automatic write_cmd(input logic [23:0] c);
		logic [31:0] rd;
		logic        err;
		int          waits;
		apb_xfer(1'b1, `AC97_REG_CMD, {8'h00, c}, rd, err, waits);
		check(err, 1'b0, "slverr on CMD write");
		cmd_q.push_back(c);
		cmd_t.push_back($time);
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frames_checked + n;
		wait (frames_checked >= target);
	endtask

	// Frame 0 carries nothing
	always @(negedge ac97_bitclk) begin
		if (!rst && frames_loaded == 0 && ac97_sdata_out) begin
			frame0_ones++;
		end
	end

	initial begin : capture
		logic [0:255] frm;
		logic [0:255] syn;
		logic [0:255] syn_exp;
		time          lt;
		syn_exp          = '0;
		syn_exp[0:14]    = 15'h7fff;
		syn_exp[255]     = 1'b1;
		wait (rst == 1'b0);
		wait_load_edge();    // Short sync pulse inside frame 0
		wait_load_edge();
		forever begin
			lt = $time;
			frames_loaded++;
			for (int k = 0; k < 256; k++) begin
				@(negedge ac97_bitclk);
				frm[k] = ac97_sdata_out;
				syn[k] = ac97_sync;
			end
			cap_q.push_back(frm);
			load_q.push_back(lt);
			if (syn !== syn_exp) begin
				$display("Sync pulse misplaced around frame %0d", frames_loaded);
				other_errors++;
				wait_load_edge();
			end else begin
				@(posedge ac97_bitclk);
			end
		end
	end

	initial begin : compare
		logic [0:255] got;
		logic [0:255] exp;
		time          lt;
		logic         cv;
		logic         sv;
		logic [23:0]  c;
		logic [31:0]  s;
		forever begin
			wait (cap_q.size() > 0);
			got = cap_q.pop_front();
			lt  = load_q.pop_front();
			cv  = 1'b0;
			sv  = 1'b0;
			c   = '0;
			s   = '0;
			if (frames_checked < 3) begin
				cv = 1'b1;
				c  = init_cmds[frames_checked];
			end else if (cmd_q.size() > 0 && cmd_t[0] < lt) begin
				cv = 1'b1;
				c  = cmd_q.pop_front();
				void'(cmd_t.pop_front());
			end
			if (smp_q.size() > 0 && smp_t[0] < lt) begin    // Pushed before the load edge
				sv = 1'b1;
				s  = smp_q.pop_front();
				void'(smp_t.pop_front());
			end
			exp = expected_frame(cv, c, sv, s);
			check(got, exp, $sformatf("output frame %0d", frames_checked + 1));
			frames_checked++;
		end
	end

	// Codec drives each bit from the rising edge
	initial begin : codec
		logic [0:255] f;
		ac97_sdata_in = 1'b0;
		wait (rst == 1'b0);
		wait_load_edge();
		wait_load_edge();
		forever begin
			f    = '0;
			f[0] = 1'b1;    // Codec ready
			if (codec_req) begin
				f[1]      = 1'b1;
				f[2]      = 1'b1;
				f[16:35]  = {1'b0, codec_idx, 12'h000};
				f[36:55]  = {codec_data, 4'h0};
				codec_req = 1'b0;
			end
			for (int k = 0; k < 256; k++) begin
				ac97_sdata_in <= f[k];
				@(posedge ac97_bitclk);
			end
		end
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge ac97_bitclk);
			cycles++;
		end
		$display("Run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	initial begin : main
		logic [31:0] rd;
		logic [31:0] st0;
		logic        err;
		int          w;
		int          stalls;
		int          polls;
		init_cmds[0] = {1'b0, `AC97_IDX_RESET, 16'h0000};
		init_cmds[1] = {1'b0, `AC97_IDX_MASTER, `AC97_MASTER_INIT};
		init_cmds[2] = {1'b0, `AC97_IDX_PCM, `AC97_PCM_INIT};
		void'($urandom(32'h852af8cb));
		rst     = 1'b1;
		apb_req = '0;
		repeat (10) @(posedge ac97_bitclk);
		check(ac97_reset_b, 1'b0, "codec reset held during rst");
		rst <= 1'b0;

		wait (frames_checked >= 3);
		check(frame0_ones, 0, "frame 0 ones");
		read_reg(`AC97_REG_STATUS, rd);
		check(rd[9], 1'b1, "init done");
		check(ac97_reset_b, 1'b1, "codec reset released");

		// Random samples with gaps for empty frames
		for (int i = 0; i < 6; i++) begin
			write_sample($urandom, w);
			if (i == 2) begin
				wait_frames(3);
			end
		end
		wait (smp_q.size() == 0);
		wait_frames(2);

		stalls = 0;
		for (int i = 0; i < 20; i++) begin
			write_sample($urandom, w);
			stalls += w;
		end
		check(stalls > 0, 1'b1, "burst back-pressure");
		polls = 0;
		do begin
			read_reg(`AC97_REG_STATUS, rd);
			check(rd[4:0] <= 5'd16, 1'b1, "FIFO level bound");
			polls++;
		end while (rd[4:0] != 5'd0 && polls < 3000);
		if (rd[4:0] != 5'd0) begin
			$display("Sample FIFO never drained after the burst");
			other_errors++;
		end

		// Second command waits on busy
		wait_load_edge();
		write_cmd({1'b0, 7'h02, 16'h1f1f});
		read_reg(`AC97_REG_STATUS, rd);
		check(rd[8], 1'b1, "cmd busy");    // Next load is a frame away
		write_sample($urandom, w);
		write_cmd({1'b1, 7'h26, 16'h0000});
		write_cmd({1'b0, 7'h18, 16'h0a0a});
		wait (cmd_q.size() == 0);

		codec_idx  = 7'h26;
		codec_data = $urandom;
		codec_req  = 1'b1;
		polls      = 0;
		do begin
			read_reg(`AC97_REG_STATUS, rd);
			polls++;
		end while (!rd[10] && polls < 2000);
		if (!rd[10]) begin
			$display("Codec reply never reached the REPLY register");
			other_errors++;
		end
		read_reg(`AC97_REG_REPLY, rd);
		check(rd, {9'd0, codec_idx, codec_data}, "REPLY contents");
		read_reg(`AC97_REG_STATUS, rd);
		check(rd[10], 1'b0, "reply valid cleared");

		read_reg(`AC97_REG_STATUS, st0);
		apb_xfer(1'b1, 4'h6, 32'hffff_ffff, rd, err, w);
		check(err, 1'b1, "slverr on unmapped write");
		apb_xfer(1'b0, 4'he, 32'h0, rd, err, w);
		check(err, 1'b1, "slverr on unmapped read");
		check(rd, 32'h0, "unmapped read data");
		read_reg(`AC97_REG_STATUS, rd);
		check(rd, st0, "STATUS after unmapped access");

		wait (cmd_q.size() == 0 && smp_q.size() == 0);
		wait_frames(2);
		$display("Value errors: %0d, other errors: %0d", val_errors, other_errors);
		if (val_errors == 0 && other_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/ac97_top.sv
`timescale 1ns/10ps
`default_nettype none

module ac97_top
	import ac97_pkg::*;
(
	input  wire                ac97_bitclk,
	input  wire                rst,
	input  wire ac97_apb_req_t apb_req,
	input  wire                ac97_sdata_in,
	output wire ac97_apb_rsp_t apb_rsp,
	output wire                ac97_sdata_out,
	output wire                ac97_sync,
	output wire                ac97_reset_b
);

	logic         push;
	ac97_sample_t push_data;
	logic         pop;
	ac97_sample_t fifo_head;
	logic         fifo_empty;
	logic         fifo_full;
	logic [4:0]   fifo_level;
	ac97_cmd_t    host_cmd;
	logic         host_cmd_valid;
	ac97_cmd_t    cmd;
	logic         cmd_valid;
	logic         seq_busy;
	logic         init_done;
	logic         frame_load;
	ac97_reply_t  reply;
	logic         reply_valid;

	ac97_apb_regs regs0 (
		.ac97_bitclk   (ac97_bitclk),
		.rst           (rst),
		.apb_req       (apb_req),
		.fifo_full     (fifo_full),
		.fifo_level    (fifo_level),
		.seq_busy      (seq_busy),
		.init_done     (init_done),
		.reply         (reply),
		.reply_valid   (reply_valid),
		.apb_rsp       (apb_rsp),
		.push          (push),
		.push_data     (push_data),
		.host_cmd      (host_cmd),
		.host_cmd_valid(host_cmd_valid)
	);

	ac97_sample_fifo fifo0 (
		.ac97_bitclk(ac97_bitclk),
		.rst        (rst),
		.push       (push),
		.push_data  (push_data),
		.pop        (pop),
		.head       (fifo_head),
		.empty      (fifo_empty),
		.full       (fifo_full),
		.level      (fifo_level)
	);

	// Init writes first, then host commands
	ac97_cmd_seq seq0 (
		.ac97_bitclk   (ac97_bitclk),
		.rst           (rst),
		.host_cmd      (host_cmd),
		.host_cmd_valid(host_cmd_valid),
		.frame_load    (frame_load),
		.cmd           (cmd),
		.cmd_valid     (cmd_valid),
		.busy          (seq_busy),
		.init_done     (init_done)
	);

	ac97_link link0 (
		.ac97_bitclk   (ac97_bitclk),
		.rst           (rst),
		.ac97_sdata_in (ac97_sdata_in),
		.cmd           (cmd),
		.cmd_valid     (cmd_valid),
		.fifo_empty    (fifo_empty),
		.fifo_head     (fifo_head),
		.ac97_sdata_out(ac97_sdata_out),
		.ac97_sync     (ac97_sync),
		.ac97_reset_b  (ac97_reset_b),
		.frame_load    (frame_load),
		.pop           (pop),
		.reply         (reply),
		.reply_valid   (reply_valid)
	);

endmodule

`default_nettype wire

// File: hdl/ac97_link.sv
`timescale 1ns/10ps
`default_nettype none

module ac97_link
	import ac97_pkg::*;
(
	input  wire               ac97_bitclk,
	input  wire               rst,
	input  wire               ac97_sdata_in,
	input  wire ac97_cmd_t    cmd,
	input  wire               cmd_valid,
	input  wire               fifo_empty,
	input  wire ac97_sample_t fifo_head,
	output logic              ac97_sdata_out,
	output logic              ac97_sync,
	output logic              ac97_reset_b,
	output logic              frame_load,
	output logic              pop,
	output ac97_reply_t       reply,
	output logic              reply_valid
);

	logic [7:0]   bit_cnt;     // Bit now on the line
	logic [7:0]   bit_cnt_nx;
	ac97_frame_t  frame_nx;
	logic [255:0] out_shift;
	logic [255:0] in_shift;
	ac97_frame_t  in_frame;

	assign bit_cnt_nx = bit_cnt + 8'd1;
	assign frame_load = (bit_cnt == 8'd255);
	assign pop        = frame_load && !fifo_empty;

	// Next frame, slots 5 to 12 stay invalid
	always_comb begin
		frame_nx        = '0;
		frame_nx.tag[0] = 1'b1;
		if (cmd_valid) begin
			frame_nx.tag[1]          = 1'b1;
			frame_nx.slot[1].cmd.rw  = cmd.rw;
			frame_nx.slot[1].cmd.idx = cmd.idx;
			// Reads carry no data
			if (!cmd.rw) begin
				frame_nx.tag[2]             = 1'b1;
				frame_nx.slot[2].pcm.sample = cmd.data;
			end
		end
		if (!fifo_empty) begin
			frame_nx.tag[3]             = 1'b1;
			frame_nx.tag[4]             = 1'b1;
			frame_nx.slot[3].pcm.sample = fifo_head.left;
			frame_nx.slot[4].pcm.sample = fifo_head.right;
		end
	end

	// Frame counter, sync and serializer
	always_ff @(posedge ac97_bitclk or posedge rst) begin
		if (rst) begin
			bit_cnt        <= 8'd0;
			ac97_sync      <= 1'b0;
			ac97_sdata_out <= 1'b0;
			ac97_reset_b   <= 1'b0;
			out_shift      <= '0;     // Frame 0 is empty
		end else begin
			bit_cnt      <= bit_cnt_nx;
			ac97_reset_b <= 1'b1;
			// Rises with the last bit, drops after the tag
			ac97_sync    <= (bit_cnt_nx == 8'd255) || (bit_cnt_nx < 8'd15);
			if (frame_load) begin
				ac97_sdata_out <= frame_nx[255];
				out_shift      <= {frame_nx[254:0], 1'b0};
			end else begin
				ac97_sdata_out <= out_shift[255];
				out_shift      <= {out_shift[254:0], 1'b0};
			end
		end
	end

	// Codec changes data on the rising edge, sample in mid bit
	always_ff @(negedge ac97_bitclk) begin
		in_shift <= {in_shift[254:0], ac97_sdata_in};
	end

	// Holds the whole input frame by the load edge
	assign in_frame = in_shift;

	always_ff @(posedge ac97_bitclk or posedge rst) begin
		if (rst) begin
			reply_valid <= 1'b0;
		end else begin
			// Codec ready plus status address and data valid
			reply_valid <= frame_load && in_frame.tag[0] && in_frame.tag[1]
				&& in_frame.tag[2];
		end
	end

	always_ff @(posedge ac97_bitclk) begin
		if (frame_load) begin
			reply.idx  <= in_frame.slot[1].cmd.idx;
			reply.data <= in_frame.slot[2].pcm.sample;    // Same layout as PCM
		end
	end

endmodule

`default_nettype wire

// File: hdl/ac97_cmd_seq.sv
`timescale 1ns/10ps
`default_nettype none

`include "ac97_cfg.svh"

module ac97_cmd_seq
	import ac97_pkg::*;
(
	input  wire            ac97_bitclk,
	input  wire            rst,
	input  wire ac97_cmd_t host_cmd,
	input  wire            host_cmd_valid,
	input  wire            frame_load,
	output ac97_cmd_t      cmd,
	output logic           cmd_valid,
	output logic           busy,
	output logic           init_done
);

	typedef enum logic [2:0] {
		INIT_RESET,
		INIT_MASTER,
		INIT_PCM,
		IDLE,
		HOST
	} state_t;

	state_t    state;
	state_t    state_nx;
	ac97_cmd_t pend;          // Host command waiting for a frame
	logic      pend_valid;

	// Each state lasts until its frame is loaded
	always_comb begin
		state_nx = state;
		case (state)
			INIT_RESET: begin
				if (frame_load) begin
					state_nx = INIT_MASTER;
				end
			end
			INIT_MASTER: begin
				if (frame_load) begin
					state_nx = INIT_PCM;
				end
			end
			INIT_PCM: begin
				if (frame_load) begin
					state_nx = (pend_valid || host_cmd_valid) ? HOST : IDLE;
				end
			end
			IDLE: begin
				if (host_cmd_valid) begin
					state_nx = HOST;
				end
			end
			HOST: begin
				if (frame_load) begin
					state_nx = IDLE;
				end
			end
			default: state_nx = INIT_RESET;
		endcase
	end

	always_ff @(posedge ac97_bitclk or posedge rst) begin
		if (rst) begin
			state      <= INIT_RESET;
			pend_valid <= 1'b0;
		end else begin
			state <= state_nx;
			if (host_cmd_valid) begin
				pend_valid <= 1'b1;
			end else if ((state == HOST) && frame_load) begin
				pend_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge ac97_bitclk) begin
		if (host_cmd_valid) begin
			pend <= host_cmd;
		end
	end

	always_comb begin
		cmd       = '0;
		cmd_valid = 1'b1;
		case (state)
			INIT_RESET:  cmd = '{rw: 1'b0, idx: `AC97_IDX_RESET, data: 16'h0000};
			INIT_MASTER: cmd = '{rw: 1'b0, idx: `AC97_IDX_MASTER, data: `AC97_MASTER_INIT};
			INIT_PCM:    cmd = '{rw: 1'b0, idx: `AC97_IDX_PCM, data: `AC97_PCM_INIT};
			HOST:        cmd = pend;
			default:     cmd_valid = 1'b0;
		endcase
	end

	assign busy      = pend_valid;
	assign init_done = (state == IDLE) || (state == HOST);

endmodule

`default_nettype wire

// File: hdl/ac97_sample_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "ac97_cfg.svh"

module ac97_sample_fifo
	import ac97_pkg::*;
(
	input  wire               ac97_bitclk,
	input  wire               rst,
	input  wire               push,
	input  wire ac97_sample_t push_data,
	input  wire               pop,
	output ac97_sample_t      head,
	output logic              empty,
	output logic              full,
	output logic [4:0]        level
);

	localparam int DEPTH = `AC97_FIFO_DEPTH;
	localparam int AW    = `AC97_FIFO_AW;

	ac97_sample_t  mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;    // One bit wider than the pointers
	logic          do_push;
	logic          do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Pointers wrap on their own
	always_ff @(posedge ac97_bitclk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // Both or neither
			endcase
		end
	end

	always_ff @(posedge ac97_bitclk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	assign head  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == (AW + 1)'(DEPTH));
	assign level = count;

endmodule

`default_nettype wire

// File: hdl/ac97_apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "ac97_cfg.svh"

module ac97_apb_regs
	import ac97_pkg::*;
(
	input  wire                ac97_bitclk,
	input  wire                rst,
	input  wire ac97_apb_req_t apb_req,
	input  wire                fifo_full,
	input  wire [4:0]          fifo_level,
	input  wire                seq_busy,
	input  wire                init_done,
	input  wire ac97_reply_t   reply,
	input  wire                reply_valid,
	output ac97_apb_rsp_t      apb_rsp,
	output logic               push,
	output ac97_sample_t       push_data,
	output ac97_cmd_t          host_cmd,
	output logic               host_cmd_valid
);

	logic        access;
	logic        stall;
	logic        unmapped;
	logic        rd_reply;
	ac97_reply_t reply_q;
	logic        reply_vld;
	logic [31:0] status_word;

	assign access = apb_req.sel && apb_req.enable;

	// Back-pressure and address check
	always_comb begin
		stall    = 1'b0;
		unmapped = 1'b0;
		case (apb_req.addr)
			`AC97_REG_SAMPLE: begin
				stall = apb_req.write && fifo_full;
			end
			`AC97_REG_CMD: begin
				stall = apb_req.write && seq_busy;
			end
			`AC97_REG_STATUS,
			`AC97_REG_REPLY: begin
				stall = 1'b0;
			end
			default: begin
				unmapped = 1'b1;
			end
		endcase
	end

	// Side effects only on the completing edge
	assign push = access && apb_req.write && !stall
		&& (apb_req.addr == `AC97_REG_SAMPLE);
	assign host_cmd_valid = access && apb_req.write && !stall
		&& (apb_req.addr == `AC97_REG_CMD);
	assign rd_reply = access && !apb_req.write && (apb_req.addr == `AC97_REG_REPLY);

	assign push_data = ac97_sample_t'(apb_req.wdata);
	assign host_cmd  = ac97_cmd_t'(apb_req.wdata[23:0]);

	assign status_word = {21'd0, reply_vld, init_done, seq_busy, 3'd0, fifo_level};

	always_comb begin
		apb_rsp.ready  = access && !stall;
		apb_rsp.slverr = access && unmapped;
		apb_rsp.rdata  = '0;
		if (access && !apb_req.write) begin
			case (apb_req.addr)
				`AC97_REG_STATUS: apb_rsp.rdata = status_word;
				`AC97_REG_REPLY:  apb_rsp.rdata = {9'd0, reply_q.idx, reply_q.data};
				default:          apb_rsp.rdata = '0;
			endcase
		end
	end

	// Sticky valid, a fresh reply wins over the clearing read
	always_ff @(posedge ac97_bitclk or posedge rst) begin
		if (rst) begin
			reply_vld <= 1'b0;
		end else if (reply_valid) begin
			reply_vld <= 1'b1;
		end else if (rd_reply) begin
			reply_vld <= 1'b0;
		end
	end

	always_ff @(posedge ac97_bitclk) begin
		if (reply_valid) begin
			reply_q <= reply;
		end
	end

endmodule

`default_nettype wire

// File: hdl/ac97_pkg.sv
`default_nettype none

package ac97_pkg;

	// Command address, also the status address coming back
	typedef struct packed {
		logic        rw;
		logic [6:0]  idx;
		logic [11:0] reserved;
	} ac97_slot_cmd_t;

	typedef struct packed {
		logic [15:0] sample;
		logic [3:0]  pad;
	} ac97_slot_pcm_t;

	typedef union packed {
		ac97_slot_cmd_t cmd;
		ac97_slot_pcm_t pcm;
	} ac97_slot_u;

	// Full AC-link frame, tag bit 0 goes out first
	typedef struct packed {
		logic [0:15]       tag;
		ac97_slot_u [1:12] slot;
	} ac97_frame_t;

	typedef struct packed {
		logic [15:0] right;
		logic [15:0] left;    // Low half of the APB word
	} ac97_sample_t;

	typedef struct packed {
		logic        rw;      // 1 for read
		logic [6:0]  idx;
		logic [15:0] data;
	} ac97_cmd_t;

	typedef struct packed {
		logic [6:0]  idx;
		logic [15:0] data;
	} ac97_reply_t;

	typedef struct packed {
		logic        sel;
		logic        enable;
		logic        write;
		logic [3:0]  addr;
		logic [31:0] wdata;
	} ac97_apb_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        ready;
		logic        slverr;
	} ac97_apb_rsp_t;

endpackage

`default_nettype wire

// File: hdl/ac97_cfg.svh
`ifndef AC97_CFG_SVH
`define AC97_CFG_SVH

// Sample FIFO size, depth must stay a power of two
`define AC97_FIFO_DEPTH   16
`define AC97_FIFO_AW      4

// APB register offsets
`define AC97_REG_SAMPLE   4'h0
`define AC97_REG_CMD      4'h4
`define AC97_REG_STATUS   4'h8
`define AC97_REG_REPLY    4'hC

// Codec register indices
`define AC97_IDX_RESET    7'h00
`define AC97_IDX_MASTER   7'h02
`define AC97_IDX_PCM      7'h18

// Init data
`define AC97_MASTER_INIT  16'h0000    // Unmuted, full volume
`define AC97_PCM_INIT     16'h0808    // Unmuted, 0 dB

`endif
